/* flist.f */
src/gat_pkg.sv
src/gat_bram.sv
src/wh_ctrl.sv
src/wh_mac.sv
src/gat_top.sv
test/gat_checker.sv
test/tb_gat_top.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_gat_top
FLIST      := flist.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

# The log decides pass or fail
run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi
	@grep -q "test passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/tb_gat_top.sv */
// WH core testbench
`default_nettype none
`timescale 1ns/10ps

module tb_gat_top;

  localparam int TIMEOUT_CYCLES = 2000;

  logic                                 clk;
  logic                                 reset;
  logic [gat_pkg::H_DATA_WIDTH-1:0]     h_data_bram_din;
  logic                                 h_data_bram_wea;
  logic [gat_pkg::H_DATA_ADDR_W-1:0]    h_data_bram_addra;
  logic [gat_pkg::ROW_LEN_WIDTH-1:0]    h_node_info_bram_din;
  logic                                 h_node_info_bram_wea;
  logic [gat_pkg::NODE_INFO_ADDR_W-1:0] h_node_info_bram_addra;
  logic [gat_pkg::WGT_ROW_WIDTH-1:0]    wgt_bram_din;
  logic                                 wgt_bram_wea;
  logic [gat_pkg::COL_IDX_WIDTH-1:0]    wgt_bram_addra;
  logic                                 h_data_bram_load_done;
  logic                                 h_node_info_bram_load_done;
  logic                                 wgt_bram_load_done;
  logic [gat_pkg::NODE_INFO_ADDR_W-1:0] feat_bram_addrb;
  logic [gat_pkg::WH_WIDTH-1:0]         feat_bram_dout;
  logic                                 gat_ready;
  logic [3:0]                           test_id;
  int                                   checker_errors;
  int                                   checks;
  int                                   tb_errors;
  bit                                   timed_out;

  // Stimulus images of the three memories
  logic [gat_pkg::H_DATA_WIDTH-1:0]     h_words [gat_pkg::H_NUM_SPARSE_DATA];
  logic [gat_pkg::ROW_LEN_WIDTH-1:0]    lens    [gat_pkg::TOTAL_NODES];
  logic [gat_pkg::WGT_ROW_WIDTH-1:0]    wgts    [1 << gat_pkg::COL_IDX_WIDTH];

  gat_top uut (
    .clk                        (clk),
    .reset                      (reset),
    .h_data_bram_din            (h_data_bram_din),
    .h_data_bram_wea            (h_data_bram_wea),
    .h_data_bram_addra          (h_data_bram_addra),
    .h_node_info_bram_din       (h_node_info_bram_din),
    .h_node_info_bram_wea       (h_node_info_bram_wea),
    .h_node_info_bram_addra     (h_node_info_bram_addra),
    .wgt_bram_din               (wgt_bram_din),
    .wgt_bram_wea               (wgt_bram_wea),
    .wgt_bram_addra             (wgt_bram_addra),
    .h_data_bram_load_done      (h_data_bram_load_done),
    .h_node_info_bram_load_done (h_node_info_bram_load_done),
    .wgt_bram_load_done         (wgt_bram_load_done),
    .feat_bram_addrb            (feat_bram_addrb),
    .feat_bram_dout             (feat_bram_dout),
    .gat_ready                  (gat_ready)
  );

  gat_checker chk (
    .clk                    (clk),
    .h_data_bram_din        (h_data_bram_din),
    .h_data_bram_wea        (h_data_bram_wea),
    .h_data_bram_addra      (h_data_bram_addra),
    .h_node_info_bram_din   (h_node_info_bram_din),
    .h_node_info_bram_wea   (h_node_info_bram_wea),
    .h_node_info_bram_addra (h_node_info_bram_addra),
    .wgt_bram_din           (wgt_bram_din),
    .wgt_bram_wea           (wgt_bram_wea),
    .wgt_bram_addra         (wgt_bram_addra),
    .gat_ready              (gat_ready),
    .feat_bram_addrb        (feat_bram_addrb),
    .feat_bram_dout         (feat_bram_dout),
    .test_id                (test_id),
    .errors                 (checker_errors),
    .checks                 (checks)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic finish_run(input bit failed_wait);
    if (checks == 0) begin
      $display("no readback value was ever compared");
      tb_errors++;
    end
    $display("checker errors %0d, testbench errors %0d, compares %0d",
             checker_errors, tb_errors, checks);
    if (!failed_wait && checker_errors == 0 && tb_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  task automatic check_not_ready(input string phase);
    if (gat_ready) begin
      tb_errors++;
      $display("gat_ready was high during %s", phase);
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    reset                      = 1'b1;
    h_data_bram_load_done      = 1'b0;
    h_node_info_bram_load_done = 1'b0;
    wgt_bram_load_done         = 1'b0;
    feat_bram_addrb            = '0;
    repeat (8) @(negedge clk);
    reset = 1'b0;
  endtask

  // ====================================================================
  // Stimulus builders
  // ====================================================================
  task automatic build_random(input bit with_zero_rows);
    for (int a = 0; a < gat_pkg::H_NUM_SPARSE_DATA; a++) begin
      h_words[a] = {8'($urandom),
                    gat_pkg::COL_IDX_WIDTH'($urandom_range(gat_pkg::NUM_FEATURE_IN - 1))};
    end
    for (int n = 0; n < gat_pkg::TOTAL_NODES; n++) begin
      lens[n] = gat_pkg::ROW_LEN_WIDTH'(1 + $urandom_range(3));
      // Nodes 0, 5, 10 and 15 are empty
      if (with_zero_rows && (n % 5 == 0)) begin
        lens[n] = '0;
      end
    end
    for (int r = 0; r < (1 << gat_pkg::COL_IDX_WIDTH); r++) begin
      wgts[r] = $urandom;
    end
  endtask

  task automatic build_extreme();
    // Full rows start at multiples of 11, so column is address mod 11
    for (int a = 0; a < gat_pkg::H_NUM_SPARSE_DATA; a++) begin
      h_words[a] = {8'h80, gat_pkg::COL_IDX_WIDTH'(a % gat_pkg::NUM_FEATURE_IN)};
    end
    for (int n = 0; n < gat_pkg::TOTAL_NODES; n++) begin
      lens[n] = (n % 3 == 1) ? gat_pkg::ROW_LEN_WIDTH'(gat_pkg::NUM_FEATURE_IN) : '0;
    end
    for (int r = 0; r < (1 << gat_pkg::COL_IDX_WIDTH); r++) begin
      wgts[r] = {4{8'h80}};
    end
  endtask

  task automatic load_memories();
    for (int a = 0; a < gat_pkg::H_NUM_SPARSE_DATA; a++) begin
      @(negedge clk);
      check_not_ready("the H load");
      h_data_bram_wea   = 1'b1;
      h_data_bram_addra = gat_pkg::H_DATA_ADDR_W'(a);
      h_data_bram_din   = h_words[a];
    end
    @(negedge clk);
    h_data_bram_wea       = 1'b0;
    h_data_bram_load_done = 1'b1;
    for (int n = 0; n < gat_pkg::TOTAL_NODES; n++) begin
      @(negedge clk);
      check_not_ready("the row length load");
      h_node_info_bram_wea   = 1'b1;
      h_node_info_bram_addra = gat_pkg::NODE_INFO_ADDR_W'(n);
      h_node_info_bram_din   = lens[n];
    end
    @(negedge clk);
    h_node_info_bram_wea       = 1'b0;
    h_node_info_bram_load_done = 1'b1;
    // Two of three levels high
    repeat (5) begin
      @(negedge clk);
      check_not_ready("a partial load");
    end
    for (int r = 0; r < (1 << gat_pkg::COL_IDX_WIDTH); r++) begin
      @(negedge clk);
      check_not_ready("the weight load");
      wgt_bram_wea   = 1'b1;
      wgt_bram_addra = gat_pkg::COL_IDX_WIDTH'(r);
      wgt_bram_din   = wgts[r];
    end
    @(negedge clk);
    wgt_bram_wea       = 1'b0;
    wgt_bram_load_done = 1'b1;
  endtask

  task automatic wait_ready();
    for (int c = 0; c < TIMEOUT_CYCLES; c++) begin
      @(negedge clk);
      if (gat_ready) begin
        return;
      end
    end
    $display("timeout, gat_ready did not rise within %0d cycles", TIMEOUT_CYCLES);
    timed_out = 1'b1;
  endtask

  task automatic sweep(input logic [3:0] id);
    test_id = id;
    for (int n = 0; n < gat_pkg::TOTAL_NODES; n++) begin
      @(negedge clk);
      feat_bram_addrb = gat_pkg::NODE_INFO_ADDR_W'(n);
      if (!gat_ready) begin
        tb_errors++;
        $display("gat_ready dropped without a reset");
      end
    end
    // Let the last read land
    repeat (2) @(negedge clk);
  endtask

  task automatic run_core();
    apply_reset();
    load_memories();
    wait_ready();
  endtask

  // ====================================================================
  // Test sequence
  // ====================================================================
  initial begin
    reset                      = 1'b1;
    h_data_bram_din            = '0;
    h_data_bram_wea            = 1'b0;
    h_data_bram_addra          = '0;
    h_node_info_bram_din       = '0;
    h_node_info_bram_wea       = 1'b0;
    h_node_info_bram_addra     = '0;
    wgt_bram_din               = '0;
    wgt_bram_wea               = 1'b0;
    wgt_bram_addra             = '0;
    h_data_bram_load_done      = 1'b0;
    h_node_info_bram_load_done = 1'b0;
    wgt_bram_load_done         = 1'b0;
    feat_bram_addrb            = '0;
    test_id                    = 4'd2;
    tb_errors                  = 0;
    timed_out                  = 1'b0;
    void'($urandom(32'hb1fe_b1bd));

    build_random(1'b0);
    run_core();
    if (!timed_out) begin
      sweep(4'd2);
      sweep(4'd5);
      build_random(1'b1);
      run_core();
    end
    if (!timed_out) begin
      sweep(4'd3);
      build_extreme();
      run_core();
    end
    if (!timed_out) begin
      sweep(4'd4);
    end

    finish_run(timed_out);
  end

endmodule

`default_nettype wire

/* test/gat_checker.sv */
// WH readback checker
`default_nettype none
`timescale 1ns/10ps

module gat_checker (
  input  logic                                clk,
  input  logic [gat_pkg::H_DATA_WIDTH-1:0]     h_data_bram_din,
  input  logic                                h_data_bram_wea,
  input  logic [gat_pkg::H_DATA_ADDR_W-1:0]    h_data_bram_addra,
  input  logic [gat_pkg::ROW_LEN_WIDTH-1:0]    h_node_info_bram_din,
  input  logic                                h_node_info_bram_wea,
  input  logic [gat_pkg::NODE_INFO_ADDR_W-1:0] h_node_info_bram_addra,
  input  logic [gat_pkg::WGT_ROW_WIDTH-1:0]    wgt_bram_din,
  input  logic                                wgt_bram_wea,
  input  logic [gat_pkg::COL_IDX_WIDTH-1:0]    wgt_bram_addra,
  input  logic                                gat_ready,
  input  logic [gat_pkg::NODE_INFO_ADDR_W-1:0] feat_bram_addrb,
  input  logic [gat_pkg::WH_WIDTH-1:0]         feat_bram_dout,
  input  logic [3:0]                          test_id,
  output int                                  errors,
  output int                                  checks
);

  logic [gat_pkg::H_DATA_WIDTH-1:0]     h_mem   [gat_pkg::H_NUM_SPARSE_DATA];
  logic [gat_pkg::ROW_LEN_WIDTH-1:0]    len_mem [gat_pkg::TOTAL_NODES];
  logic [gat_pkg::WGT_ROW_WIDTH-1:0]    w_mem   [1 << gat_pkg::COL_IDX_WIDTH];
  logic [gat_pkg::NODE_INFO_ADDR_W-1:0] read_addr;
  logic [3:0]                           read_id;
  logic                                 ready_prev = 1'b0;
  logic [gat_pkg::WH_WIDTH-1:0]         expected;
  int                                   error_count = 0;
  int                                   check_count = 0;

  assign errors = error_count;
  assign checks = check_count;

  function automatic string test_name(input logic [3:0] id);
    case (id)
      4'd2:    return "random_rows";
      4'd3:    return "zero_rows";
      4'd4:    return "extreme_sums";
      4'd5:    return "repeat_sweep";
      default: return "unnamed";
    endcase
  endfunction

  // ====================================================================
  // Reference model of one WH row
  // ====================================================================
  function automatic logic [gat_pkg::WH_WIDTH-1:0] expected_row(input int node);
    int                               start;
    logic [gat_pkg::H_DATA_WIDTH-1:0] word;
    logic signed [7:0]                value;
    logic signed [7:0]                wgt;
    logic [gat_pkg::COL_IDX_WIDTH-1:0] col;
    logic signed [31:0]               lane_sum [gat_pkg::NUM_FEATURE_OUT];
    logic [gat_pkg::WH_WIDTH-1:0]     row;
    start = 0;
    // Rows sit back to back in H
    for (int n = 0; n < node; n++) begin
      start += int'(len_mem[n]);
    end
    for (int l = 0; l < gat_pkg::NUM_FEATURE_OUT; l++) begin
      lane_sum[l] = '0;
    end
    for (int k = 0; k < int'(len_mem[node]); k++) begin
      word  = h_mem[(start + k) % gat_pkg::H_NUM_SPARSE_DATA];
      value = word[gat_pkg::H_DATA_WIDTH-1 -: gat_pkg::DATA_WIDTH];
      col   = word[gat_pkg::COL_IDX_WIDTH-1:0];
      for (int l = 0; l < gat_pkg::NUM_FEATURE_OUT; l++) begin
        wgt         = w_mem[col][l*gat_pkg::DATA_WIDTH +: gat_pkg::DATA_WIDTH];
        lane_sum[l] = lane_sum[l] + value * wgt;
      end
    end
    for (int l = 0; l < gat_pkg::NUM_FEATURE_OUT; l++) begin
      row[l*gat_pkg::WH_DATA_WIDTH +: gat_pkg::WH_DATA_WIDTH] =
        lane_sum[l][gat_pkg::WH_DATA_WIDTH-1:0];
    end
    return row;
  endfunction

  // Mirror of the host writes
  always @(posedge clk) begin
    if (h_data_bram_wea) begin
      h_mem[h_data_bram_addra] <= h_data_bram_din;
    end
    if (h_node_info_bram_wea) begin
      len_mem[h_node_info_bram_addra] <= h_node_info_bram_din;
    end
    if (wgt_bram_wea) begin
      w_mem[wgt_bram_addra] <= wgt_bram_din;
    end
    read_addr <= feat_bram_addrb;
    read_id   <= test_id;
  end

  // Ready on two falling edges means every row was written before the read
  always @(negedge clk) begin
    ready_prev <= gat_ready;
    if (gat_ready && ready_prev) begin
      expected = expected_row(int'(read_addr));
      check_count++;
      if (feat_bram_dout !== expected) begin
        error_count++;
        $display("FAILED %s node %0d expected %h actual %h",
                 test_name(read_id), read_addr, expected, feat_bram_dout);
      end
    end
  end

endmodule

`default_nettype wire

/* src/gat_top.sv */
// WH core top level
`default_nettype none
`timescale 1ns/10ps

module gat_top (
  input  logic                                clk,
  input  logic                                reset,

  input  logic [gat_pkg::H_DATA_WIDTH-1:0]     h_data_bram_din,
  input  logic                                h_data_bram_wea,
  input  logic [gat_pkg::H_DATA_ADDR_W-1:0]    h_data_bram_addra,

  input  logic [gat_pkg::ROW_LEN_WIDTH-1:0]    h_node_info_bram_din,
  input  logic                                h_node_info_bram_wea,
  input  logic [gat_pkg::NODE_INFO_ADDR_W-1:0] h_node_info_bram_addra,

  input  logic [gat_pkg::WGT_ROW_WIDTH-1:0]    wgt_bram_din,
  input  logic                                wgt_bram_wea,
  input  logic [gat_pkg::COL_IDX_WIDTH-1:0]    wgt_bram_addra,

  input  logic                                h_data_bram_load_done,
  input  logic                                h_node_info_bram_load_done,
  input  logic                                wgt_bram_load_done,

  input  logic [gat_pkg::NODE_INFO_ADDR_W-1:0] feat_bram_addrb,
  output logic [gat_pkg::WH_WIDTH-1:0]         feat_bram_dout,
  output logic                                gat_ready
);

  logic [gat_pkg::H_DATA_ADDR_W-1:0]    h_data_bram_addrb;
  logic [gat_pkg::H_DATA_WIDTH-1:0]     h_data_bram_dout;
  logic [gat_pkg::DATA_WIDTH-1:0]       h_value;
  logic [gat_pkg::COL_IDX_WIDTH-1:0]    h_col_idx;
  logic [gat_pkg::NODE_INFO_ADDR_W-1:0] node_info_bram_addrb;
  logic [gat_pkg::ROW_LEN_WIDTH-1:0]    row_len;
  logic [gat_pkg::COL_IDX_WIDTH-1:0]    wgt_bram_addrb;
  logic [gat_pkg::WGT_ROW_WIDTH-1:0]    wgt_row;
  logic                                 row_clear;
  logic                                 mac_valid;
  logic                                 feat_wea;
  logic [gat_pkg::NODE_INFO_ADDR_W-1:0] feat_addra;
  logic [gat_pkg::WH_WIDTH-1:0]         wh_row;

  // Value above column index
  assign h_value   = h_data_bram_dout[gat_pkg::H_DATA_WIDTH-1 -: gat_pkg::DATA_WIDTH];
  assign h_col_idx = h_data_bram_dout[gat_pkg::COL_IDX_WIDTH-1:0];

  // ====================================================================
  // Memories
  // ====================================================================
  gat_bram #(
    .data_width (gat_pkg::H_DATA_WIDTH),
    .addr_width (gat_pkg::H_DATA_ADDR_W)
  ) h_data_bram (
    .clk   (clk),
    .wea   (h_data_bram_wea),
    .addra (h_data_bram_addra),
    .din   (h_data_bram_din),
    .addrb (h_data_bram_addrb),
    .doutb (h_data_bram_dout)
  );

  gat_bram #(
    .data_width (gat_pkg::ROW_LEN_WIDTH),
    .addr_width (gat_pkg::NODE_INFO_ADDR_W)
  ) node_info_bram (
    .clk   (clk),
    .wea   (h_node_info_bram_wea),
    .addra (h_node_info_bram_addra),
    .din   (h_node_info_bram_din),
    .addrb (node_info_bram_addrb),
    .doutb (row_len)
  );

  gat_bram #(
    .data_width (gat_pkg::WGT_ROW_WIDTH),
    .addr_width (gat_pkg::COL_IDX_WIDTH)
  ) wgt_bram (
    .clk   (clk),
    .wea   (wgt_bram_wea),
    .addra (wgt_bram_addra),
    .din   (wgt_bram_din),
    .addrb (wgt_bram_addrb),
    .doutb (wgt_row)
  );

  // One WH row per node
  gat_bram #(
    .data_width (gat_pkg::WH_WIDTH),
    .addr_width (gat_pkg::NODE_INFO_ADDR_W)
  ) feat_bram (
    .clk   (clk),
    .wea   (feat_wea),
    .addra (feat_addra),
    .din   (wh_row),
    .addrb (feat_bram_addrb),
    .doutb (feat_bram_dout)
  );

  // ====================================================================
  // Control and datapath
  // ====================================================================
  wh_ctrl u_wh_ctrl (
    .clk                        (clk),
    .reset                      (reset),
    .h_data_bram_load_done      (h_data_bram_load_done),
    .h_node_info_bram_load_done (h_node_info_bram_load_done),
    .wgt_bram_load_done         (wgt_bram_load_done),
    .h_data_bram_addrb          (h_data_bram_addrb),
    .h_col_idx                  (h_col_idx),
    .node_info_bram_addrb       (node_info_bram_addrb),
    .row_len                    (row_len),
    .wgt_bram_addrb             (wgt_bram_addrb),
    .row_clear                  (row_clear),
    .mac_valid                  (mac_valid),
    .feat_wea                   (feat_wea),
    .feat_addra                 (feat_addra),
    .gat_ready                  (gat_ready)
  );

  wh_mac u_wh_mac (
    .clk       (clk),
    .reset     (reset),
    .row_clear (row_clear),
    .mac_valid (mac_valid),
    .h_value   (h_value),
    .wgt_row   (wgt_row),
    .wh_row    (wh_row)
  );

endmodule

`default_nettype wire

/* src/wh_mac.sv */
// Four-lane WH multiply-accumulate
`default_nettype none
`timescale 1ns/10ps

module wh_mac (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              row_clear,
  input  logic                              mac_valid,
  input  logic [gat_pkg::DATA_WIDTH-1:0]    h_value,
  input  logic [gat_pkg::WGT_ROW_WIDTH-1:0] wgt_row,
  output logic [gat_pkg::WH_WIDTH-1:0]      wh_row
);

  // Value arrives one cycle ahead of its weight row
  logic signed [gat_pkg::DATA_WIDTH-1:0] h_value_q;

  always_ff @(posedge clk) begin
    h_value_q <= h_value;
  end

  // ====================================================================
  // Lanes
  // ====================================================================
  for (genvar i = 0; i < gat_pkg::NUM_FEATURE_OUT; i++) begin : g_lane
    logic signed [gat_pkg::DATA_WIDTH-1:0]      wgt;
    logic signed [2*gat_pkg::DATA_WIDTH-1:0]    prod;
    logic signed [gat_pkg::WH_DATA_WIDTH-1:0]   prod_ext;
    logic signed [gat_pkg::WH_DATA_WIDTH-1:0]   acc;
    logic signed [gat_pkg::WH_DATA_WIDTH-1:0]   sum;

    assign wgt  = wgt_row[i*gat_pkg::DATA_WIDTH +: gat_pkg::DATA_WIDTH];
    assign prod = h_value_q * wgt;

    // sign extend to lane width
    assign prod_ext = {
      {(gat_pkg::WH_DATA_WIDTH - 2*gat_pkg::DATA_WIDTH){prod[2*gat_pkg::DATA_WIDTH-1]}},
      prod
    };
    assign sum = acc + prod_ext;

    always_ff @(posedge clk) begin
      if (reset) begin
        acc <= '0;
      end else if (row_clear) begin
        acc <= '0;
      end else if (mac_valid) begin
        acc <= sum;
      end
    end

    // Last product is folded in on the write cycle
    assign wh_row[i*gat_pkg::WH_DATA_WIDTH +: gat_pkg::WH_DATA_WIDTH] = mac_valid ? sum : acc;
  end

  // Clear only between rows, never with a product in flight
  a_clear_not_during_mac: assert property (
    @(posedge clk) disable iff (reset) !(row_clear && mac_valid)
  );

endmodule

`default_nettype wire

/* src/wh_ctrl.sv */
// WH node walker
`default_nettype none
`timescale 1ns/10ps

module wh_ctrl (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                h_data_bram_load_done,
  input  logic                                h_node_info_bram_load_done,
  input  logic                                wgt_bram_load_done,
  output logic [gat_pkg::H_DATA_ADDR_W-1:0]    h_data_bram_addrb,
  input  logic [gat_pkg::COL_IDX_WIDTH-1:0]    h_col_idx,
  output logic [gat_pkg::NODE_INFO_ADDR_W-1:0] node_info_bram_addrb,
  input  logic [gat_pkg::ROW_LEN_WIDTH-1:0]    row_len,
  output logic [gat_pkg::COL_IDX_WIDTH-1:0]    wgt_bram_addrb,
  output logic                                row_clear,
  output logic                                mac_valid,
  output logic                                feat_wea,
  output logic [gat_pkg::NODE_INFO_ADDR_W-1:0] feat_addra,
  output logic                                gat_ready
);

  logic [gat_pkg::STATE_WIDTH-1:0]      state;
  logic [gat_pkg::STATE_WIDTH-1:0]      state_next;
  logic [gat_pkg::H_DATA_ADDR_W-1:0]    h_ptr;
  logic                                 h_ptr_moved;
  // Node whose length is on the node memory output
  logic [gat_pkg::NODE_INFO_ADDR_W-1:0] node;
  logic [gat_pkg::NODE_INFO_ADDR_W-1:0] cur_node;
  logic [gat_pkg::ROW_LEN_WIDTH-1:0]    remaining;
  logic                                 all_loaded;
  logic                                 issue;
  logic                                 issue_last;
  logic                                 zero_row;

  // Two-stage delay line matching the memory read latency
  logic                                 d1_valid;
  logic                                 d1_last;
  logic [gat_pkg::NODE_INFO_ADDR_W-1:0] d1_node;
  logic                                 d2_valid;
  logic                                 d2_last;
  logic [gat_pkg::NODE_INFO_ADDR_W-1:0] d2_node;

  assign all_loaded = h_data_bram_load_done && h_node_info_bram_load_done && wgt_bram_load_done;
  assign issue      = (state == gat_pkg::ST_STREAM);
  assign issue_last = issue && (remaining == gat_pkg::ROW_LEN_WIDTH'(1));
  assign zero_row   = (state == gat_pkg::ST_READ_LEN) && (row_len == '0);

  assign h_data_bram_addrb    = h_ptr;
  assign node_info_bram_addrb = node;
  // Column index selects the weight row
  assign wgt_bram_addrb       = h_col_idx;

  assign row_clear  = (state == gat_pkg::ST_READ_LEN);
  assign mac_valid  = d2_valid;
  assign feat_wea   = d2_last;
  assign feat_addra = d2_node;
  assign gat_ready  = (state == gat_pkg::ST_DONE);

  // ====================================================================
  // FSM
  // ====================================================================
  always_comb begin
    state_next = state;
    case (state)
      gat_pkg::ST_IDLE: begin
        if (all_loaded) begin
          state_next = gat_pkg::ST_READ_LEN;
        end
      end
      gat_pkg::ST_READ_LEN: begin
        state_next = zero_row ? gat_pkg::ST_DRAIN : gat_pkg::ST_STREAM;
      end
      gat_pkg::ST_STREAM: begin
        if (issue_last) begin
          state_next = gat_pkg::ST_DRAIN;
        end
      end
      gat_pkg::ST_DRAIN: begin
        // Leave on the row's write cycle
        if (feat_wea) begin
          state_next = (feat_addra == gat_pkg::LAST_NODE) ? gat_pkg::ST_DONE
                                                          : gat_pkg::ST_READ_LEN;
        end
      end
      gat_pkg::ST_DONE: begin
        state_next = gat_pkg::ST_DONE;
      end
      default: begin
        state_next = gat_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= gat_pkg::ST_IDLE;
      h_ptr       <= '0;
      h_ptr_moved <= 1'b0;
      node        <= '0;
      remaining   <= '0;
      d1_valid    <= 1'b0;
      d1_last     <= 1'b0;
      d2_valid    <= 1'b0;
      d2_last     <= 1'b0;
    end else begin
      state <= state_next;
      if (issue) begin
        h_ptr       <= h_ptr + gat_pkg::H_DATA_ADDR_W'(1);
        h_ptr_moved <= 1'b1;
      end
      // Next node's length is fetched while this one streams
      if (state == gat_pkg::ST_READ_LEN) begin
        node      <= node + gat_pkg::NODE_INFO_ADDR_W'(1);
        remaining <= row_len;
      end else if (issue) begin
        remaining <= remaining - gat_pkg::ROW_LEN_WIDTH'(1);
      end
      d1_valid <= issue;
      d1_last  <= issue_last;
      d2_valid <= d1_valid;
      // Empty row skips ahead so its write lands next cycle
      d2_last  <= d1_last || zero_row;
    end
  end

  always_ff @(posedge clk) begin
    if (state == gat_pkg::ST_READ_LEN) begin
      cur_node <= node;
    end
    d1_node <= cur_node;
    d2_node <= zero_row ? node : d1_node;
  end

  // Once streaming began, the H pointer must not come back around to zero
  a_h_ptr_no_wrap: assert property (
    @(posedge clk) disable iff (reset) issue && h_ptr_moved |-> h_ptr != '0
  );

endmodule

`default_nettype wire

/* src/gat_bram.sv */
// Simple dual-port memory
`default_nettype none
`timescale 1ns/10ps

module gat_bram #(
  parameter int data_width = 8,
  parameter int addr_width = 4
) (
  input  logic                  clk,
  input  logic                  wea,
  input  logic [addr_width-1:0] addra,
  input  logic [data_width-1:0] din,
  input  logic [addr_width-1:0] addrb,
  output logic [data_width-1:0] doutb
);

  logic [data_width-1:0] mem [0:(1 << addr_width)-1];

  // Read before write on a shared address
  always_ff @(posedge clk) begin
    if (wea) begin
      mem[addra] <= din;
    end
    doutb <= mem[addrb];
  end

  // Host write address must be known
  a_write_in_range: assert property (
    @(posedge clk) wea |-> !$isunknown(addra)
  );

endmodule

`default_nettype wire

/* src/gat_pkg.sv */
// WH stage sizes and encodings
`default_nettype none

package gat_pkg;

  // ====================================================================
  // Problem shape
  // ====================================================================
  localparam int DATA_WIDTH        = 8;
  localparam int NUM_FEATURE_IN    = 11;
  localparam int NUM_FEATURE_OUT   = 4;
  localparam int TOTAL_NODES       = 16;
  localparam int H_NUM_SPARSE_DATA = 64;

  // ====================================================================
  // Memory words and addresses
  // ====================================================================
  // H data word is {value, column index}
  localparam int COL_IDX_WIDTH    = $clog2(NUM_FEATURE_IN);
  localparam int H_DATA_WIDTH     = DATA_WIDTH + COL_IDX_WIDTH;
  localparam int H_DATA_ADDR_W    = $clog2(H_NUM_SPARSE_DATA);

  // A full row holds NUM_FEATURE_IN entries
  localparam int ROW_LEN_WIDTH    = $clog2(NUM_FEATURE_IN + 1);
  localparam int NODE_INFO_ADDR_W = $clog2(TOTAL_NODES);

  // Lane 0 sits in the low bits of W and WH rows
  localparam int WGT_ROW_WIDTH    = DATA_WIDTH * NUM_FEATURE_OUT;
  localparam int WH_DATA_WIDTH    = 20;
  localparam int WH_WIDTH         = WH_DATA_WIDTH * NUM_FEATURE_OUT;

  localparam logic [NODE_INFO_ADDR_W-1:0] LAST_NODE = NODE_INFO_ADDR_W'(TOTAL_NODES - 1);

  // ====================================================================
  // Controller FSM
  // ====================================================================
  localparam int STATE_WIDTH = 3;

  localparam logic [STATE_WIDTH-1:0] ST_IDLE     = 3'd0;
  localparam logic [STATE_WIDTH-1:0] ST_READ_LEN = 3'd1;
  localparam logic [STATE_WIDTH-1:0] ST_STREAM   = 3'd2;
  localparam logic [STATE_WIDTH-1:0] ST_DRAIN    = 3'd3;
  localparam logic [STATE_WIDTH-1:0] ST_DONE     = 3'd4;

endpackage

`default_nettype wire
